// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - files:
      - rtl/exec_pkg.sv
      - rtl/fu_req_if.sv
      - rtl/fu_result_if.sv
      - rtl/operand_select.sv
      - rtl/alu_unit.sv
      - rtl/shift_add_mul.sv
      - rtl/cdb_merge.sv
      - rtl/exec_top.sv
  - target: test
    files:
      - testbench/exec_props.sv
      - testbench/tb_exec_top.sv

// ==== filelist.f ====
rtl/exec_pkg.sv
rtl/fu_req_if.sv
rtl/fu_result_if.sv
rtl/operand_select.sv
rtl/alu_unit.sv
rtl/shift_add_mul.sv
rtl/cdb_merge.sv
rtl/exec_top.sv
testbench/exec_props.sv
testbench/tb_exec_top.sv

// ==== rtl/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_unit #(
    parameter int TAG_W = 4
) (
    input  logic         clk,
    input  logic         rst,
    fu_req_if.unit       req,
    fu_result_if.src     res
);

    exec_pkg::word_t   alu_out;
    logic              cmp_out;
    logic [4:0]        shamt;

    logic              valid_q;
    logic [TAG_W-1:0]  tag_q;
    exec_pkg::word_t   value_q;
    logic              br_taken_q;

    // Only the low 5 bits of b shift
    assign shamt = req.b[4:0];

    always_comb begin
        unique case (req.alu_op)
            exec_pkg::alu_add:  alu_out = req.a + req.b;
            exec_pkg::alu_sub:  alu_out = req.a - req.b;
            exec_pkg::alu_sll:  alu_out = req.a << shamt;
            exec_pkg::alu_slt:  alu_out = {31'd0, $signed(req.a) < $signed(req.b)};
            exec_pkg::alu_sltu: alu_out = {31'd0, req.a < req.b};
            exec_pkg::alu_xor:  alu_out = req.a ^ req.b;
            exec_pkg::alu_srl:  alu_out = req.a >> shamt;
            // Arithmetic shift keeps the sign bit
            exec_pkg::alu_sra:  alu_out = exec_pkg::word_t'($signed(req.a) >>> shamt);
            exec_pkg::alu_or:   alu_out = req.a | req.b;
            exec_pkg::alu_and:  alu_out = req.a & req.b;
            default:            alu_out = '0;
        endcase
    end

    // Branch condition on register operands
    always_comb begin
        unique case (req.cmp_op)
            exec_pkg::cmp_beq:  cmp_out = (req.cmp_a == req.cmp_b);
            exec_pkg::cmp_bne:  cmp_out = (req.cmp_a != req.cmp_b);
            exec_pkg::cmp_blt:  cmp_out = ($signed(req.cmp_a) < $signed(req.cmp_b));
            exec_pkg::cmp_bge:  cmp_out = ($signed(req.cmp_a) >= $signed(req.cmp_b));
            exec_pkg::cmp_bltu: cmp_out = (req.cmp_a < req.cmp_b);
            exec_pkg::cmp_bgeu: cmp_out = (req.cmp_a >= req.cmp_b);
            default:            cmp_out = 1'b0;
        endcase
    end

    // Result strobe one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    // Payload only follows accepted requests
    always_ff @(posedge clk) begin
        if (req.valid) begin
            tag_q      <= req.tag;
            value_q    <= alu_out;
            // Non-branch ops never report taken
            br_taken_q <= req.is_branch && cmp_out;
        end
    end

    assign res.valid    = valid_q;
    assign res.tag      = tag_q;
    assign res.value    = value_q;
    assign res.br_taken = br_taken_q;

endmodule

`default_nettype wire

// ==== rtl/cdb_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

module cdb_merge #(
    parameter int TAG_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    fu_result_if.dst           alu_res,
    fu_result_if.dst           mul_res,
    output logic               alu_ready,
    output logic               cdb_valid,
    output logic [TAG_W-1:0]   cdb_tag,
    output exec_pkg::word_t    cdb_value,
    output logic               cdb_br_taken
);

    // One-entry hold for an ALU result pushed aside by the multiplier
    logic              hold_valid;
    logic [TAG_W-1:0]  hold_tag;
    exec_pkg::word_t   hold_value;
    logic              hold_br_taken;
    logic              alu_to_hold;

    // ALU waits when the bus slot goes to the multiplier or the hold entry
    assign alu_to_hold = alu_res.valid && (mul_res.valid || hold_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid  <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            cdb_valid  <= mul_res.valid || hold_valid || alu_res.valid;
            // Hold drains unless the multiplier takes the bus again
            hold_valid <= alu_to_hold || (hold_valid && mul_res.valid);
        end
    end

    // Newer ALU result replaces a draining entry
    always_ff @(posedge clk) begin
        if (alu_to_hold) begin
            hold_tag      <= alu_res.tag;
            hold_value    <= alu_res.value;
            hold_br_taken <= alu_res.br_taken;
        end
    end

    // Bus word priority is multiplier then hold then ALU
    always_ff @(posedge clk) begin
        if (mul_res.valid) begin
            cdb_tag      <= mul_res.tag;
            cdb_value    <= mul_res.value;
            cdb_br_taken <= mul_res.br_taken;
        end else if (hold_valid) begin
            cdb_tag      <= hold_tag;
            cdb_value    <= hold_value;
            cdb_br_taken <= hold_br_taken;
        end else if (alu_res.valid) begin
            cdb_tag      <= alu_res.tag;
            cdb_value    <= alu_res.value;
            cdb_br_taken <= alu_res.br_taken;
        end
    end

    assign alu_ready = !hold_valid;

endmodule

`default_nettype wire

// ==== rtl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // Multiplier iterations with one partial product per cycle
    parameter int MUL_STEPS = 32;

    // Data word for operands, pc, immediate and results
    typedef logic [31:0] word_t;

    // Full 64-bit product of the multiplier
    typedef logic [63:0] dword_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // RV32I integer operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // Branch conditions
    typedef enum logic [2:0] {
        cmp_beq  = 3'd0,
        cmp_bne  = 3'd1,
        cmp_blt  = 3'd2,
        cmp_bge  = 3'd3,
        cmp_bltu = 3'd4,
        cmp_bgeu = 3'd5
    } cmp_op_t;

    // RV32M multiply flavours
    // mul gives the low word and the others the high word
    typedef enum logic [1:0] {
        mul_mul    = 2'd0,
        mul_mulh   = 2'd1,
        mul_mulhsu = 2'd2,
        mul_mulhu  = 2'd3
    } mul_op_t;

    // Multiplier sequencer
    typedef enum logic [1:0] {
        mul_idle   = 2'd0,
        mul_run    = 2'd1,
        mul_finish = 2'd2
    } mul_state_t;

endpackage

`default_nettype wire

// ==== rtl/exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_top #(
    parameter int TAG_W = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  logic [TAG_W-1:0]     issue_tag,
    input  logic                 issue_is_mul,
    input  logic                 issue_is_branch,
    input  exec_pkg::alu_op_t    issue_alu_op,
    input  exec_pkg::cmp_op_t    issue_cmp_op,
    input  exec_pkg::mul_op_t    issue_mul_op,
    input  logic                 issue_a_is_pc,
    input  logic                 issue_b_is_imm,
    input  exec_pkg::reg_idx_t   issue_rs1_idx,
    input  exec_pkg::reg_idx_t   issue_rs2_idx,
    input  exec_pkg::word_t      issue_rs1_val,
    input  exec_pkg::word_t      issue_rs2_val,
    input  exec_pkg::word_t      issue_pc,
    input  exec_pkg::word_t      issue_imm,
    output logic                 alu_ready,
    output logic                 mul_ready,
    output logic                 cdb_valid,
    output logic [TAG_W-1:0]     cdb_tag,
    output exec_pkg::word_t      cdb_value,
    output logic                 cdb_br_taken
);

    // Request channels into the two units
    fu_req_if    #(.TAG_W(TAG_W)) alu_req ();
    fu_req_if    #(.TAG_W(TAG_W)) mul_req ();
    // Result channels into the CDB combiner
    fu_result_if #(.TAG_W(TAG_W)) alu_res ();
    fu_result_if #(.TAG_W(TAG_W)) mul_res ();

    operand_select #(.TAG_W(TAG_W)) u_operand_select (
        .issue_valid     (issue_valid),
        .issue_tag       (issue_tag),
        .issue_is_mul    (issue_is_mul),
        .issue_is_branch (issue_is_branch),
        .issue_alu_op    (issue_alu_op),
        .issue_cmp_op    (issue_cmp_op),
        .issue_mul_op    (issue_mul_op),
        .issue_a_is_pc   (issue_a_is_pc),
        .issue_b_is_imm  (issue_b_is_imm),
        .issue_rs1_idx   (issue_rs1_idx),
        .issue_rs2_idx   (issue_rs2_idx),
        .issue_rs1_val   (issue_rs1_val),
        .issue_rs2_val   (issue_rs2_val),
        .issue_pc        (issue_pc),
        .issue_imm       (issue_imm),
        .alu_req         (alu_req.src),
        .mul_req         (mul_req.src)
    );

    alu_unit #(.TAG_W(TAG_W)) u_alu_unit (
        .clk (clk),
        .rst (rst),
        .req (alu_req.unit),
        .res (alu_res.src)
    );

    shift_add_mul #(.TAG_W(TAG_W)) u_shift_add_mul (
        .clk       (clk),
        .rst       (rst),
        .req       (mul_req.unit),
        .res       (mul_res.src),
        .mul_ready (mul_ready)
    );

    cdb_merge #(.TAG_W(TAG_W)) u_cdb_merge (
        .clk          (clk),
        .rst          (rst),
        .alu_res      (alu_res.dst),
        .mul_res      (mul_res.dst),
        .alu_ready    (alu_ready),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .cdb_br_taken (cdb_br_taken)
    );

endmodule

`default_nettype wire

// ==== rtl/fu_req_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One operand-ready request from operand select to a functional unit
interface fu_req_if #(
    parameter int TAG_W = 4
);
    logic                  valid;
    logic [TAG_W-1:0]      tag;
    // ALU operands already steered from pc, imm or registers
    exec_pkg::word_t       a;
    exec_pkg::word_t       b;
    // Compare operands always come from registers
    exec_pkg::word_t       cmp_a;
    exec_pkg::word_t       cmp_b;
    exec_pkg::alu_op_t     alu_op;
    exec_pkg::cmp_op_t     cmp_op;
    logic                  is_branch;
    exec_pkg::mul_op_t     mul_op;

    modport src (
        output valid, tag, a, b, cmp_a, cmp_b, alu_op, cmp_op, is_branch, mul_op
    );

    modport unit (
        input valid, tag, a, b, cmp_a, cmp_b, alu_op, cmp_op, is_branch, mul_op
    );

endinterface

`default_nettype wire

// ==== rtl/fu_result_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One finished result from a functional unit toward the CDB combiner
interface fu_result_if #(
    parameter int TAG_W = 4
);
    // Single-cycle strobe
    logic              valid;
    logic [TAG_W-1:0]  tag;
    exec_pkg::word_t   value;
    // Only the ALU ever raises this
    logic              br_taken;

    modport src (
        output valid, tag, value, br_taken
    );

    modport dst (
        input valid, tag, value, br_taken
    );

endinterface

`default_nettype wire

// ==== rtl/operand_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_select #(
    parameter int TAG_W = 4
) (
    input  logic                 issue_valid,
    input  logic [TAG_W-1:0]     issue_tag,
    input  logic                 issue_is_mul,
    input  logic                 issue_is_branch,
    input  exec_pkg::alu_op_t    issue_alu_op,
    input  exec_pkg::cmp_op_t    issue_cmp_op,
    input  exec_pkg::mul_op_t    issue_mul_op,
    input  logic                 issue_a_is_pc,
    input  logic                 issue_b_is_imm,
    input  exec_pkg::reg_idx_t   issue_rs1_idx,
    input  exec_pkg::reg_idx_t   issue_rs2_idx,
    input  exec_pkg::word_t      issue_rs1_val,
    input  exec_pkg::word_t      issue_rs2_val,
    input  exec_pkg::word_t      issue_pc,
    input  exec_pkg::word_t      issue_imm,
    fu_req_if.src                alu_req,
    fu_req_if.src                mul_req
);

    exec_pkg::word_t rs1_eff;
    exec_pkg::word_t rs2_eff;
    exec_pkg::word_t op_a;
    exec_pkg::word_t op_b;

    // x0 reads as zero whatever value came along
    assign rs1_eff = (issue_rs1_idx == '0) ? '0 : issue_rs1_val;
    assign rs2_eff = (issue_rs2_idx == '0) ? '0 : issue_rs2_val;

    // pc for auipc, jumps and branch targets
    assign op_a = issue_a_is_pc ? issue_pc : rs1_eff;
    // Branch target is pc + imm while the condition still sees the registers
    assign op_b = issue_b_is_imm ? issue_imm : rs2_eff;

    // Strobe goes to exactly one unit
    assign alu_req.valid = issue_valid && !issue_is_mul;
    assign mul_req.valid = issue_valid && issue_is_mul;

    // Operand payload is shared by both channels
    assign alu_req.tag       = issue_tag;
    assign alu_req.a         = op_a;
    assign alu_req.b         = op_b;
    assign alu_req.cmp_a     = rs1_eff;
    assign alu_req.cmp_b     = rs2_eff;
    assign alu_req.alu_op    = issue_alu_op;
    assign alu_req.cmp_op    = issue_cmp_op;
    assign alu_req.is_branch = issue_is_branch;
    assign alu_req.mul_op    = issue_mul_op;

    assign mul_req.tag       = issue_tag;
    assign mul_req.a         = op_a;
    assign mul_req.b         = op_b;
    assign mul_req.cmp_a     = rs1_eff;
    assign mul_req.cmp_b     = rs2_eff;
    assign mul_req.alu_op    = issue_alu_op;
    assign mul_req.cmp_op    = issue_cmp_op;
    assign mul_req.is_branch = issue_is_branch;
    assign mul_req.mul_op    = issue_mul_op;

endmodule

`default_nettype wire

// ==== rtl/shift_add_mul.sv ====
`timescale 1ns/100ps
`default_nettype none

module shift_add_mul #(
    parameter int TAG_W = 4
) (
    input  logic         clk,
    input  logic         rst,
    fu_req_if.unit       req,
    fu_result_if.src     res,
    output logic         mul_ready
);

    localparam int CNT_W = $clog2(exec_pkg::MUL_STEPS);

    exec_pkg::mul_state_t  state;
    logic [CNT_W-1:0]      step_cnt;

    logic [TAG_W-1:0]      tag_q;
    exec_pkg::mul_op_t     op_q;
    exec_pkg::word_t       mcand;
    // High half accumulates while the low half holds the shifting multiplier
    exec_pkg::dword_t      prod;
    logic                  neg_q;

    logic                  a_signed;
    logic                  b_signed;
    exec_pkg::word_t       a_mag;
    exec_pkg::word_t       b_mag;
    logic [32:0]           sum;
    exec_pkg::dword_t      prod_fixed;

    // mulhsu treats only a as signed
    assign a_signed = (req.mul_op == exec_pkg::mul_mulh) || (req.mul_op == exec_pkg::mul_mulhsu);
    assign b_signed = (req.mul_op == exec_pkg::mul_mulh);

    // 0x80000000 maps onto itself as an unsigned magnitude
    assign a_mag = (a_signed && req.a[31]) ? (~req.a + 32'd1) : req.a;
    assign b_mag = (b_signed && req.b[31]) ? (~req.b + 32'd1) : req.b;

    // Add the multiplicand when the current multiplier bit is set
    assign sum = {1'b0, prod[63:32]} + (prod[0] ? {1'b0, mcand} : 33'd0);

    // Restore the sign of the full product
    assign prod_fixed = neg_q ? (~prod + 64'd1) : prod;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= exec_pkg::mul_idle;
            step_cnt <= '0;
        end else begin
            unique case (state)
                exec_pkg::mul_idle: begin
                    step_cnt <= '0;
                    if (req.valid) begin
                        state <= exec_pkg::mul_run;
                    end
                end
                exec_pkg::mul_run: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == CNT_W'(exec_pkg::MUL_STEPS - 1)) begin
                        state <= exec_pkg::mul_finish;
                    end
                end
                exec_pkg::mul_finish: begin
                    state <= exec_pkg::mul_idle;
                end
                default: state <= exec_pkg::mul_idle;
            endcase
        end
    end

    // Operand latch on start and then one add-and-shift per run cycle
    always_ff @(posedge clk) begin
        if (state == exec_pkg::mul_idle && req.valid) begin
            tag_q <= req.tag;
            op_q  <= req.mul_op;
            mcand <= a_mag;
            prod  <= {32'd0, b_mag};
            neg_q <= (a_signed && req.a[31]) ^ (b_signed && req.b[31]);
        end else if (state == exec_pkg::mul_run) begin
            prod <= {sum, prod[31:1]};
        end
    end

    assign mul_ready = (state == exec_pkg::mul_idle);

    // One-cycle result pulse in finish
    assign res.valid    = (state == exec_pkg::mul_finish);
    assign res.tag      = tag_q;
    assign res.value    = (op_q == exec_pkg::mul_mul) ? prod_fixed[31:0] : prod_fixed[63:32];
    assign res.br_taken = 1'b0;

endmodule

`default_nettype wire

// ==== testbench/exec_props.sv ====
`timescale 1ns/100ps
`default_nettype none

// Protocol checks on the execute stage boundary
module exec_props #(
    parameter int TAG_W = 4
) (
    input logic               clk,
    input logic               rst,
    input logic               issue_valid,
    input logic               issue_is_mul,
    input logic [TAG_W-1:0]   issue_tag,
    input logic               alu_ready,
    input logic               mul_ready,
    input logic               mul_done,
    input logic               cdb_valid,
    input logic [TAG_W-1:0]   cdb_tag,
    input exec_pkg::word_t    cdb_value,
    input logic               cdb_br_taken
);

    // Count of failed properties
    int violations = 0;

    // Reset leaves the bus quiet and both units open
    reset_state: assert property (@(posedge clk)
        rst |=> (!cdb_valid && alu_ready && mul_ready))
    else begin
        $error("bus or ready levels wrong right after reset");
        violations++;
    end

    // Environment only issues into a ready unit
    issue_to_ready: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> (issue_is_mul ? mul_ready : alu_ready))
    else begin
        $error("issue raised while the selected unit was busy");
        violations++;
    end

    cdb_known: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> !$isunknown({cdb_tag, cdb_value, cdb_br_taken}))
    else begin
        $error("unknown bits on the CDB while cdb_valid is high");
        violations++;
    end

    // Multiplier leaves idle right after it accepts
    mul_busy_after_issue: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && issue_is_mul) |=> !mul_ready)
    else begin
        $error("mul_ready still high the cycle after a multiply issue");
        violations++;
    end

    // No multiply result and an empty hold one cycle later means a clean path
    alu_two_cycles: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && !issue_is_mul) ##1 (!mul_done && alu_ready)
        |=> (cdb_valid && cdb_tag == $past(issue_tag, 2)))
    else begin
        $error("non-colliding ALU result missed its 2-cycle CDB slot");
        violations++;
    end

endmodule

bind exec_top exec_props #(.TAG_W(TAG_W)) u_exec_props (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_is_mul (issue_is_mul),
    .issue_tag    (issue_tag),
    .alu_ready    (alu_ready),
    .mul_ready    (mul_ready),
    .mul_done     (mul_res.valid),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .cdb_value    (cdb_value),
    .cdb_br_taken (cdb_br_taken)
);

`default_nettype wire

// ==== testbench/tb_exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exec_top;

    localparam int TAG_W       = 4;
    localparam int NTAGS       = 1 << TAG_W;
    localparam int WAIT_LIMIT  = 4 * exec_pkg::MUL_STEPS;
    localparam int DRAIN_LIMIT = 8 * exec_pkg::MUL_STEPS;

    logic               clk;
    logic               rst;
    logic               issue_valid;
    logic [TAG_W-1:0]   issue_tag;
    logic               issue_is_mul;
    logic               issue_is_branch;
    exec_pkg::alu_op_t  issue_alu_op;
    exec_pkg::cmp_op_t  issue_cmp_op;
    exec_pkg::mul_op_t  issue_mul_op;
    logic               issue_a_is_pc;
    logic               issue_b_is_imm;
    exec_pkg::reg_idx_t issue_rs1_idx;
    exec_pkg::reg_idx_t issue_rs2_idx;
    exec_pkg::word_t    issue_rs1_val;
    exec_pkg::word_t    issue_rs2_val;
    exec_pkg::word_t    issue_pc;
    exec_pkg::word_t    issue_imm;
    logic               alu_ready;
    logic               mul_ready;
    logic               cdb_valid;
    logic [TAG_W-1:0]   cdb_tag;
    exec_pkg::word_t    cdb_value;
    logic               cdb_br_taken;

    // Tag-keyed scoreboard
    logic               pending [NTAGS];
    exec_pkg::word_t    exp_value [NTAGS];
    logic               exp_br [NTAGS];
    int                 arrival [NTAGS];
    int                 outstanding = 0;
    int                 arrivals = 0;
    int                 tag_ptr = 0;
    int                 last_tag;
    logic               saw_hold;

    exec_top #(.TAG_W(TAG_W)) i_exec_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // Inputs move half a nanosecond after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    function automatic exec_pkg::word_t model_alu(exec_pkg::alu_op_t op,
                                                  exec_pkg::word_t a, exec_pkg::word_t b);
        exec_pkg::dword_t ext;
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            exec_pkg::alu_add:  return a + b;
            exec_pkg::alu_sub:  return a + ~b + 32'd1;
            exec_pkg::alu_sll:  return a << b[4:0];
            // Differing signs decide by the sign of a alone
            exec_pkg::alu_slt:  return (a[31] != b[31]) ? 32'(a[31]) : 32'(a < b);
            exec_pkg::alu_sltu: return 32'(a < b);
            exec_pkg::alu_xor:  return a ^ b;
            exec_pkg::alu_srl:  return a >> b[4:0];
            exec_pkg::alu_sra:  return ext[31:0];
            exec_pkg::alu_or:   return a | b;
            default:            return a & b;
        endcase
    endfunction

    function automatic logic model_cmp(exec_pkg::cmp_op_t op, exec_pkg::word_t x,
                                       exec_pkg::word_t y);
        exec_pkg::word_t xs;
        exec_pkg::word_t ys;
        // Flipped sign bit turns signed order into unsigned order
        xs = x ^ 32'h8000_0000;
        ys = y ^ 32'h8000_0000;
        case (op)
            exec_pkg::cmp_beq:  return x == y;
            exec_pkg::cmp_bne:  return x != y;
            exec_pkg::cmp_blt:  return xs < ys;
            exec_pkg::cmp_bge:  return !(xs < ys);
            exec_pkg::cmp_bltu: return x < y;
            default:            return !(x < y);
        endcase
    endfunction

    function automatic exec_pkg::word_t model_mul(exec_pkg::mul_op_t op, exec_pkg::word_t a,
                                                  exec_pkg::word_t b);
        exec_pkg::dword_t ea;
        exec_pkg::dword_t eb;
        exec_pkg::dword_t p;
        ea = (op == exec_pkg::mul_mulh || op == exec_pkg::mul_mulhsu) ?
             {{32{a[31]}}, a} : {32'd0, a};
        eb = (op == exec_pkg::mul_mulh) ? {{32{b[31]}}, b} : {32'd0, b};
        // Modulo 2^64 product already holds the right high word
        p = ea * eb;
        return (op == exec_pkg::mul_mul) ? p[31:0] : p[63:32];
    endfunction

    function automatic int free_tag();
        int t;
        for (int k = 0; k < NTAGS; k++) begin
            t = (tag_ptr + k) % NTAGS;
            if (!pending[t]) begin
                return t;
            end
        end
        return -1;
    endfunction

    function automatic exec_pkg::word_t pick_word();
        case ($urandom_range(0, 5))
            0: return 32'h8000_0000;
            1: return 32'hFFFF_FFFF;
            2: return 32'h0000_0000;
            3: return $urandom_range(0, 40);
            default: return $urandom();
        endcase
    endfunction

    task automatic roll_common();
        issue_rs1_idx = 5'($urandom_range(0, 7));
        issue_rs2_idx = 5'($urandom_range(0, 7));
        issue_rs1_val = pick_word();
        issue_rs2_val = pick_word();
        issue_pc      = {30'($urandom_range(0, 32'h3FFF_FFFF)), 2'b00};
        issue_imm     = pick_word();
    endtask

    task automatic roll_alu();
        roll_common();
        issue_is_mul    = 1'b0;
        issue_is_branch = 1'b0;
        issue_alu_op    = exec_pkg::alu_op_t'($urandom_range(0, 9));
        issue_a_is_pc   = ($urandom_range(0, 3) == 0);
        issue_b_is_imm  = ($urandom_range(0, 1) == 1);
    endtask

    // Target is pc + imm while the condition uses the registers
    task automatic roll_branch(input exec_pkg::cmp_op_t op);
        roll_common();
        issue_is_mul    = 1'b0;
        issue_is_branch = 1'b1;
        issue_cmp_op    = op;
        issue_alu_op    = exec_pkg::alu_add;
        issue_a_is_pc   = 1'b1;
        issue_b_is_imm  = 1'b1;
        if ($urandom_range(0, 2) == 0) begin
            issue_rs2_val = issue_rs1_val;
        end
    endtask

    task automatic roll_mul(input exec_pkg::mul_op_t op);
        roll_common();
        issue_is_mul    = 1'b1;
        issue_is_branch = 1'b0;
        issue_mul_op    = op;
        issue_a_is_pc   = 1'b0;
        issue_b_is_imm  = 1'b0;
        issue_rs1_idx   = 5'($urandom_range(1, 31));
        issue_rs2_idx   = 5'($urandom_range(1, 31));
    endtask

    // Waits for a free tag and a ready unit, books the expected result, strobes once
    task automatic send();
        int              waited;
        int              t;
        exec_pkg::word_t ca;
        exec_pkg::word_t cb;
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        waited = 0;
        t = free_tag();
        while (t < 0 || !(issue_is_mul ? mul_ready : alu_ready)) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("no free tag or ready unit before the timeout");
            end
            next_cycle();
            waited++;
            t = free_tag();
        end
        ca = (issue_rs1_idx == 0) ? 32'd0 : issue_rs1_val;
        cb = (issue_rs2_idx == 0) ? 32'd0 : issue_rs2_val;
        a  = issue_a_is_pc ? issue_pc : ca;
        b  = issue_b_is_imm ? issue_imm : cb;
        if (issue_is_mul) begin
            exp_value[t] = model_mul(issue_mul_op, a, b);
            exp_br[t]    = 1'b0;
        end else begin
            exp_value[t] = model_alu(issue_alu_op, a, b);
            exp_br[t]    = issue_is_branch && model_cmp(issue_cmp_op, ca, cb);
        end
        pending[t]  = 1'b1;
        outstanding++;
        last_tag    = t;
        tag_ptr     = (t + 1) % NTAGS;
        issue_tag   = TAG_W'(t);
        issue_valid = 1'b1;
        next_cycle();
        issue_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        int first;
        waited = 0;
        while (outstanding != 0) begin
            if (waited == DRAIN_LIMIT) begin
                first = -1;
                for (int k = NTAGS - 1; k >= 0; k--) begin
                    if (pending[k]) first = k;
                end
                abort_run($sformatf("tag %0d never arrived on the CDB", first));
            end
            next_cycle();
            waited++;
        end
    endtask

    // Scoreboard check in the middle of the cycle
    always @(negedge clk) begin
        if (!rst && cdb_valid) begin
            if ($isunknown(cdb_tag) || !pending[cdb_tag]) begin
                abort_run($sformatf("tag %0d appeared on the CDB with nothing outstanding",
                                    cdb_tag));
            end else begin
                assert (cdb_value === exp_value[cdb_tag])
                else abort_run($sformatf(
                    "[FAIL] %0t cdb_value tag %0d expected %h observed %h",
                    $time, cdb_tag, exp_value[cdb_tag], cdb_value));
                assert (cdb_br_taken === exp_br[cdb_tag])
                else abort_run($sformatf(
                    "[FAIL] %0t cdb_br_taken tag %0d expected %b observed %b",
                    $time, cdb_tag, exp_br[cdb_tag], cdb_br_taken));
                pending[cdb_tag] = 1'b0;
                arrival[cdb_tag] = arrivals;
                arrivals++;
                outstanding--;
            end
        end
        if (!rst && !alu_ready) saw_hold = 1'b1;
        if (i_exec_top.u_exec_props.violations != 0) begin
            abort_run("a bound protocol assertion failed");
        end
    end

    initial begin
        int mul_tag;
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(32'h9e85_541f));
        foreach (pending[k]) pending[k] = 1'b0;
        saw_hold        = 1'b0;
        rst             = 1'b1;
        issue_valid     = 1'b0;
        issue_tag       = '0;
        issue_is_mul    = 1'b0;
        issue_is_branch = 1'b0;
        issue_alu_op    = exec_pkg::alu_add;
        issue_cmp_op    = exec_pkg::cmp_beq;
        issue_mul_op    = exec_pkg::mul_mul;
        issue_a_is_pc   = 1'b0;
        issue_b_is_imm  = 1'b0;
        issue_rs1_idx   = '0;
        issue_rs2_idx   = '0;
        issue_rs1_val   = '0;
        issue_rs2_val   = '0;
        issue_pc        = '0;
        issue_imm       = '0;
        repeat (16) @(posedge clk);
        #0.5;
        rst = 1'b0;
        assert (!cdb_valid && alu_ready && mul_ready)
        else abort_run("bus busy or a unit not ready after reset");

        // Every ALU op with shifts seeing the full b but using 5 bits
        for (int op = 0; op < 10; op++) begin
            repeat (6) begin
                roll_alu();
                issue_alu_op = exec_pkg::alu_op_t'(op);
                send();
            end
        end
        // x0 with a nonzero value across the pc and imm choices
        for (int sel = 0; sel < 4; sel++) begin
            roll_alu();
            issue_alu_op   = exec_pkg::alu_add;
            issue_a_is_pc  = sel[0];
            issue_b_is_imm = sel[1];
            issue_rs1_idx  = '0;
            issue_rs2_idx  = '0;
            issue_rs1_val  = 32'hDEAD_BEEF;
            issue_rs2_val  = 32'h1234_5678;
            send();
        end
        for (int op = 0; op < 6; op++) begin
            repeat (6) begin
                roll_branch(exec_pkg::cmp_op_t'(op));
                send();
            end
        end
        for (int op = 0; op < 4; op++) begin
            repeat (5) begin
                roll_mul(exec_pkg::mul_op_t'(op));
                send();
            end
        end
        drain();

        // ALU result lands in the same cycle as the multiply result
        saw_hold = 1'b0;
        roll_mul(exec_pkg::mul_mulhsu);
        send();
        mul_tag = last_tag;
        repeat (exec_pkg::MUL_STEPS - 1) next_cycle();
        roll_alu();
        send();
        drain();
        assert (arrival[mul_tag] < arrival[last_tag])
        else abort_run("ALU result overtook the colliding multiply on the CDB");
        assert (saw_hold)
        else abort_run("alu_ready never dropped while the hold register was full");

        // Random mix with idle gaps
        repeat (160) begin
            case ($urandom_range(0, 4))
                0: roll_mul(exec_pkg::mul_op_t'($urandom_range(0, 3)));
                1: roll_branch(exec_pkg::cmp_op_t'($urandom_range(0, 5)));
                default: roll_alu();
            endcase
            send();
            repeat ($urandom_range(0, 2)) next_cycle();
        end
        drain();

        if (outstanding == 0 && i_exec_top.u_exec_props.violations == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("results still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire
